/* logic/intra4_pkg.sv */
//----------------------------------------
// Shared types and constants for the 4x4 intra mode picker
// Referenced by scoped name from every RTL module
//----------------------------------------
`default_nettype none

package intra4_pkg;

    //----------------------------------------
    // Widths and counts
    //----------------------------------------
    localparam int unsigned PIXEL_W    = 8;
    localparam int unsigned NUM_MODES  = 4;
    localparam int unsigned BLK_PIXELS = 16;
    localparam int unsigned LAMBDA_W   = 16;
    localparam int unsigned SSE_W      = 21;
    localparam int unsigned SCORE_W    = 32;
    localparam int unsigned SSE_SHIFT  = 8;
    localparam int unsigned COST_W     = 11;

    //----------------------------------------
    // Pixel data
    //----------------------------------------
    typedef logic [PIXEL_W-1:0] pixel_t;

    // Raster order, element 0 is the top-left pixel
    typedef pixel_t [BLK_PIXELS-1:0] block_t;

    // top[3:0] sit above the block, top[7:4] above-right
    typedef struct packed {
        pixel_t         top_left;
        pixel_t [7:0]   top;
        pixel_t [3:0]   left;
    } neighbours_t;

    //----------------------------------------
    // Modes
    //----------------------------------------
    typedef enum logic [1:0] {
        DC = 2'd0,
        TM = 2'd1,
        VE = 2'd2,
        HE = 2'd3
    } mode_e;

    // Fixed header cost per mode, indexed by mode_e
    localparam logic [COST_W-1:0] MODE_COST [NUM_MODES] = '{
        11'd40,
        11'd1151,
        11'd1723,
        11'd1874
    };

    // One candidate travelling down the SSE pipeline
    typedef struct packed {
        mode_e  mode;
        logic   last;
        block_t pred;
    } cand_t;

endpackage

`default_nettype wire

/* logic/intra4_predictor.sv */
//----------------------------------------
// Combinational 4x4 luma predictor for DC, TM, VE and HE
// Output follows mode_i and the neighbour pixels directly
//----------------------------------------
`default_nettype none

module intra4_predictor (
    input  intra4_pkg::mode_e       mode_i,
    input  intra4_pkg::neighbours_t nbr_i,
    output intra4_pkg::block_t      pred_o
);

    // Three-tap 1-2-1 smoothing with rounding
    function automatic intra4_pkg::pixel_t avg3(
        input intra4_pkg::pixel_t a,
        input intra4_pkg::pixel_t b,
        input intra4_pkg::pixel_t c
    );
        logic [intra4_pkg::PIXEL_W+1:0] s;
        s = (intra4_pkg::PIXEL_W+2)'(a)
          + ((intra4_pkg::PIXEL_W+2)'(b) << 1)
          + (intra4_pkg::PIXEL_W+2)'(c)
          + (intra4_pkg::PIXEL_W+2)'(2);
        return s[intra4_pkg::PIXEL_W+1:2];
    endfunction

    // left + top - top_left, saturated to the pixel range
    function automatic intra4_pkg::pixel_t tm_clip(
        input intra4_pkg::pixel_t l,
        input intra4_pkg::pixel_t t,
        input intra4_pkg::pixel_t tl
    );
        logic [intra4_pkg::PIXEL_W+1:0] v;
        v = (intra4_pkg::PIXEL_W+2)'(l)
          + (intra4_pkg::PIXEL_W+2)'(t)
          - (intra4_pkg::PIXEL_W+2)'(tl);
        if (v[intra4_pkg::PIXEL_W+1]) begin
            return '0;
        end else if (v[intra4_pkg::PIXEL_W]) begin
            return '1;
        end
        return v[intra4_pkg::PIXEL_W-1:0];
    endfunction

    logic [intra4_pkg::PIXEL_W+2:0] dc_sum;
    intra4_pkg::pixel_t             dc_val;
    intra4_pkg::pixel_t             ext_top  [6];
    intra4_pkg::pixel_t             ext_left [6];
    intra4_pkg::pixel_t             ve_col   [4];
    intra4_pkg::pixel_t             he_row   [4];

    //----------------------------------------
    // Per-mode building blocks
    //----------------------------------------
    always_comb begin
        dc_sum = (intra4_pkg::PIXEL_W+3)'(4);
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum
                   + (intra4_pkg::PIXEL_W+3)'(nbr_i.top[i])
                   + (intra4_pkg::PIXEL_W+3)'(nbr_i.left[i]);
        end
        dc_val = dc_sum[intra4_pkg::PIXEL_W+2:3];

        // Row above, extended by top_left and the first above-right pixel
        ext_top[0] = nbr_i.top_left;
        for (int i = 0; i < 5; i++) begin
            ext_top[i+1] = nbr_i.top[i];
        end

        // Column to the left, bottom pixel repeated
        ext_left[0] = nbr_i.top_left;
        for (int i = 0; i < 4; i++) begin
            ext_left[i+1] = nbr_i.left[i];
        end
        ext_left[5] = nbr_i.left[3];

        for (int i = 0; i < 4; i++) begin
            ve_col[i] = avg3(ext_top[i], ext_top[i+1], ext_top[i+2]);
            he_row[i] = avg3(ext_left[i], ext_left[i+1], ext_left[i+2]);
        end
    end

    //----------------------------------------
    // Mode mux
    //----------------------------------------
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                case (mode_i)
                    intra4_pkg::DC: pred_o[r*4+c] = dc_val;
                    intra4_pkg::TM: pred_o[r*4+c] = tm_clip(nbr_i.left[r], nbr_i.top[c],
                                                            nbr_i.top_left);
                    intra4_pkg::VE: pred_o[r*4+c] = ve_col[c];
                    default:        pred_o[r*4+c] = he_row[r];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/intra4_sse.sv */
//----------------------------------------
// Two-stage SSE pipeline taking one candidate per cycle
// Candidate rides alongside so mode and prediction stay matched
//----------------------------------------
`default_nettype none

module intra4_sse (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid_i,
    input  intra4_pkg::cand_t               cand_i,
    input  intra4_pkg::block_t              src_i,
    output logic                            out_valid_o,
    output intra4_pkg::cand_t               cand_o,
    output logic [intra4_pkg::SSE_W-1:0]    sse_o
);

    function automatic logic [2*intra4_pkg::PIXEL_W-1:0] sq_diff(
        input intra4_pkg::pixel_t a,
        input intra4_pkg::pixel_t b
    );
        intra4_pkg::pixel_t d;
        d = (a > b) ? a - b : b - a;
        return (2*intra4_pkg::PIXEL_W)'(d) * (2*intra4_pkg::PIXEL_W)'(d);
    endfunction

    logic [intra4_pkg::SSE_W-1:0]   row_sum [4];
    logic [intra4_pkg::SSE_W-1:0]   row_q   [4];
    logic                           valid_s1_q;
    intra4_pkg::cand_t              cand_s1_q;

    // Stage one per-row sums
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < 4; c++) begin
                row_sum[r] = row_sum[r]
                           + intra4_pkg::SSE_W'(sq_diff(src_i[r*4+c], cand_i.pred[r*4+c]));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1_q  <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            valid_s1_q  <= in_valid_i;
            out_valid_o <= valid_s1_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            row_q     <= row_sum;
            cand_s1_q <= cand_i;
        end
        // Stage two folds the rows
        if (valid_s1_q) begin
            sse_o  <= row_q[0] + row_q[1] + row_q[2] + row_q[3];
            cand_o <= cand_s1_q;
        end
    end

    // Each candidate comes out two cycles later unchanged
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid_i |-> ##2 (out_valid_o && cand_o == $past(cand_i, 2))
    );

endmodule

`default_nettype wire

/* logic/intra4_mode_select.sv */
//----------------------------------------
// Scores each candidate and tracks the cheapest one
// Result is presented the cycle after the last candidate
//----------------------------------------
`default_nettype none

module intra4_mode_select (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                valid_i,
    input  intra4_pkg::cand_t                   cand_i,
    input  logic [intra4_pkg::SSE_W-1:0]        sse_i,
    input  logic [intra4_pkg::LAMBDA_W-1:0]     lambda_mode_i,
    output logic                                result_valid_o,
    output intra4_pkg::mode_e                   best_mode_o,
    output logic [intra4_pkg::SCORE_W-1:0]      best_score_o,
    output intra4_pkg::block_t                  best_pred_o
);

    logic [intra4_pkg::SCORE_W-1:0] cand_score;
    logic                           first_q;
    logic                           take;
    intra4_pkg::mode_e              best_mode_q;
    logic [intra4_pkg::SCORE_W-1:0] best_score_q;
    intra4_pkg::block_t             best_pred_q;
    intra4_pkg::mode_e              nxt_mode;
    logic [intra4_pkg::SCORE_W-1:0] nxt_score;
    intra4_pkg::block_t             nxt_pred;

    // SSE << 8 plus header cost * lambda
    assign cand_score = (intra4_pkg::SCORE_W'(sse_i) << intra4_pkg::SSE_SHIFT)
                      + intra4_pkg::SCORE_W'(intra4_pkg::MODE_COST[cand_i.mode])
                      * intra4_pkg::SCORE_W'(lambda_mode_i);

    // Strictly lower wins, ties keep the earlier mode
    assign take = first_q || (cand_score < best_score_q);

    always_comb begin
        nxt_mode  = take ? cand_i.mode : best_mode_q;
        nxt_score = take ? cand_score  : best_score_q;
        nxt_pred  = take ? cand_i.pred : best_pred_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_q        <= 1'b1;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= valid_i && cand_i.last;
            if (valid_i) begin
                first_q <= cand_i.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            best_mode_q  <= nxt_mode;
            best_score_q <= nxt_score;
            best_pred_q  <= nxt_pred;
        end
        // Output copy holds until the next request finishes
        if (valid_i && cand_i.last) begin
            best_mode_o  <= nxt_mode;
            best_score_o <= nxt_score;
            best_pred_o  <= nxt_pred;
        end
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid_o |=> !result_valid_o
    );

endmodule

`default_nettype wire

/* logic/intra4_top.sv */
//----------------------------------------
// Best 4x4 intra mode picker with a start/done handshake
// Inputs must stay stable from start_i until they are latched
//----------------------------------------
`default_nettype none

module intra4_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start_i,
    input  logic [intra4_pkg::LAMBDA_W-1:0]     lambda_mode_i,
    input  intra4_pkg::block_t                  src_i,
    input  intra4_pkg::neighbours_t             nbr_i,
    output logic                                done_o,
    output intra4_pkg::mode_e                   best_mode_o,
    output logic [intra4_pkg::SCORE_W-1:0]      best_score_o,
    output intra4_pkg::block_t                  best_pred_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_e;

    state_e                             state_q;
    logic [1:0]                         mode_cnt_q;
    logic                               accept;
    logic                               last_issue;
    intra4_pkg::mode_e                  cur_mode;
    intra4_pkg::block_t                 src_q;
    intra4_pkg::neighbours_t            nbr_q;
    logic [intra4_pkg::LAMBDA_W-1:0]    lambda_q;
    intra4_pkg::block_t                 pred;
    logic                               issue_valid_q;
    intra4_pkg::cand_t                  issue_cand_q;
    logic                               sse_valid;
    intra4_pkg::cand_t                  sse_cand;
    logic [intra4_pkg::SSE_W-1:0]       sse;

    assign accept     = (state_q == S_IDLE) && start_i;
    assign cur_mode   = intra4_pkg::mode_e'(mode_cnt_q);
    assign last_issue = (mode_cnt_q == 2'(intra4_pkg::NUM_MODES - 1));

    //----------------------------------------
    // Request FSM and mode counter
    //----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= S_IDLE;
            mode_cnt_q    <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= (state_q == S_ISSUE);
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q    <= S_ISSUE;
                        mode_cnt_q <= '0;
                    end
                end
                S_ISSUE: begin
                    mode_cnt_q <= mode_cnt_q + 2'd1;
                    if (last_issue) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (done_o) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Input latches and the issue register
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q    <= src_i;
            nbr_q    <= nbr_i;
            lambda_q <= lambda_mode_i;
        end
        if (state_q == S_ISSUE) begin
            issue_cand_q.mode <= cur_mode;
            issue_cand_q.last <= last_issue;
            issue_cand_q.pred <= pred;
        end
    end

    //----------------------------------------
    // Datapath
    //----------------------------------------
    intra4_predictor u_predictor (
        .mode_i (cur_mode),
        .nbr_i  (nbr_q),
        .pred_o (pred)
    );

    intra4_sse u_sse (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (issue_valid_q),
        .cand_i      (issue_cand_q),
        .src_i       (src_q),
        .out_valid_o (sse_valid),
        .cand_o      (sse_cand),
        .sse_o       (sse)
    );

    intra4_mode_select u_mode_select (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (sse_valid),
        .cand_i         (sse_cand),
        .sse_i          (sse),
        .lambda_mode_i  (lambda_q),
        .result_valid_o (done_o),
        .best_mode_o    (best_mode_o),
        .best_score_o   (best_score_o),
        .best_pred_o    (best_pred_o)
    );

    // No candidate is in flight once the FSM is back in IDLE
    a_idle_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        state_q == S_IDLE |-> !issue_valid_q && !sse_valid
    );

endmodule

`default_nettype wire

/* testbench/tb_intra4_top.sv */
//----------------------------------------
// Self-checking testbench for intra4_top
// Model of the four predictors and the score rule
//----------------------------------------
`default_nettype none

module tb_intra4_top;

    timeunit 1ns;
    timeprecision 100ps;

    logic                               clk;
    logic                               rst_n;
    logic                               start_i;
    logic [intra4_pkg::LAMBDA_W-1:0]    lambda_mode_i;
    intra4_pkg::block_t                 src_i;
    intra4_pkg::neighbours_t            nbr_i;
    logic                               done_o;
    intra4_pkg::mode_e                  best_mode_o;
    logic [intra4_pkg::SCORE_W-1:0]     best_score_o;
    intra4_pkg::block_t                 best_pred_o;

    // Request bookkeeping and expected result
    logic                               pending;
    logic                               accept_pulse;
    intra4_pkg::mode_e                  exp_mode;
    logic [intra4_pkg::SCORE_W-1:0]     exp_score;
    intra4_pkg::block_t                 exp_pred;
    int                                 seed;

    intra4_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .lambda_mode_i (lambda_mode_i),
        .src_i         (src_i),
        .nbr_i         (nbr_i),
        .done_o        (done_o),
        .best_mode_o   (best_mode_o),
        .best_score_o  (best_score_o),
        .best_pred_o   (best_pred_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    //----------------------------------------
    // Reference model
    //----------------------------------------
    function automatic int smooth3(input int a, input int b, input int c);
        return (a + 2 * b + c + 2) >> 2;
    endfunction

    // Row above, k = -1 is the corner pixel
    function automatic int top_px(input intra4_pkg::neighbours_t n, input int k);
        int v;
        v = (k < 0) ? n.top_left : n.top[k];
        return v;
    endfunction

    // Column to the left, corner above and last pixel repeated below
    function automatic int left_px(input intra4_pkg::neighbours_t n, input int k);
        int v;
        v = (k < 0) ? n.top_left : n.left[(k > 3) ? 3 : k];
        return v;
    endfunction

    function automatic intra4_pkg::block_t predict(input int mode,
                                                   input intra4_pkg::neighbours_t n);
        intra4_pkg::block_t p;
        int                 dc;
        int                 v;
        dc = 4;
        for (int i = 0; i < 4; i++) begin
            dc = dc + top_px(n, i) + left_px(n, i);
        end
        dc = dc >> 3;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                case (mode)
                    0: v = dc;
                    1: v = left_px(n, r) + top_px(n, c) - top_px(n, -1);
                    2: v = smooth3(top_px(n, c - 1), top_px(n, c), top_px(n, c + 1));
                    default: v = smooth3(left_px(n, r - 1), left_px(n, r), left_px(n, r + 1));
                endcase
                v = (v < 0) ? 0 : ((v > 255) ? 255 : v);
                p[r * 4 + c] = 8'(v);
            end
        end
        return p;
    endfunction

    task automatic expect_best(input intra4_pkg::block_t s, input intra4_pkg::neighbours_t n,
                               input int lam);
        intra4_pkg::block_t p;
        longint             sse;
        longint             score;
        longint             best;
        int                 x;
        int                 y;
        best = 0;
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            p   = predict(m, n);
            sse = 0;
            for (int i = 0; i < intra4_pkg::BLK_PIXELS; i++) begin
                x   = s[i];
                y   = p[i];
                sse = sse + (x - y) * (x - y);
            end
            score = (sse << intra4_pkg::SSE_SHIFT)
                  + longint'(intra4_pkg::MODE_COST[m]) * lam;
            // Ties keep the earlier mode
            if (m == 0 || score < best) begin
                best     = score;
                exp_mode = intra4_pkg::mode_e'(m);
                exp_pred = p;
            end
        end
        exp_score = 32'(best);
    endtask

    //----------------------------------------
    // Stimulus
    //----------------------------------------
    task automatic random_case(input bit smooth, output intra4_pkg::block_t s,
                               output intra4_pkg::neighbours_t n, output logic [15:0] lam);
        n.top_left = 8'($random(seed));
        for (int i = 0; i < 8; i++) begin
            n.top[i] = 8'($random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            n.left[i] = 8'($random(seed));
        end
        // Smooth blocks follow the row above with a little noise
        for (int i = 0; i < intra4_pkg::BLK_PIXELS; i++) begin
            s[i] = smooth ? (n.top[i % 4] ^ 8'($random(seed) & 3)) : 8'($random(seed));
        end
        lam = 16'($random(seed));
        if (smooth) begin
            lam = lam >> 6;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done_o) begin
            if (cycles > 20) begin
                $display("timeout waiting for done_o");
                stop_on_error();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        @(posedge clk);
        pending <= 1'b0;
    endtask

    task automatic run_request(input intra4_pkg::block_t s, input intra4_pkg::neighbours_t n,
                               input logic [15:0] lam, input bit poke_busy);
        @(posedge clk);
        src_i         <= s;
        nbr_i         <= n;
        lambda_mode_i <= lam;
        start_i       <= 1'b1;
        accept_pulse  <= 1'b1;
        pending       <= 1'b1;
        @(posedge clk);
        start_i      <= 1'b0;
        accept_pulse <= 1'b0;
        // Extra start while the request is still issuing
        if (poke_busy) begin
            @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
        end
        wait_done();
    endtask

    initial begin
        intra4_pkg::block_t      s;
        intra4_pkg::neighbours_t n;
        logic [15:0]             lam;
        seed          = 34;
        rst_n         = 1'b0;
        start_i       = 1'b0;
        lambda_mode_i = '0;
        src_i         = '0;
        nbr_i         = '0;
        pending       = 1'b0;
        accept_pulse  = 1'b0;
        exp_mode      = intra4_pkg::DC;
        exp_score     = '0;
        exp_pred      = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) @(posedge clk);

        // Flat block, every mode predicts it exactly
        n.top_left = 8'h5a;
        n.top      = {8{8'h5a}};
        n.left     = {4{8'h5a}};
        s          = {16{8'h5a}};
        lam        = 16'd200;
        exp_mode   = intra4_pkg::DC;
        exp_score  = 32'(intra4_pkg::MODE_COST[intra4_pkg::DC]) * 32'(lam);
        exp_pred   = s;
        run_request(s, n, lam, 1'b0);

        // VE and HE both predict 100 everywhere, DC gives 101
        n.top_left = 8'd97;
        n.top      = {8'd100, 8'd100, 8'd100, 8'd95, 8'd104, 8'd98, 8'd101, 8'd101};
        n.left     = {8'd101, 8'd98, 8'd101, 8'd101};
        s          = {16{8'd100}};
        exp_mode   = intra4_pkg::VE;
        exp_score  = '0;
        exp_pred   = s;
        run_request(s, n, 16'd0, 1'b1);

        for (int i = 0; i < 50; i++) begin
            random_case(bit'(i % 2), s, n, lam);
            expect_best(s, n, lam);
            run_request(s, n, lam, (i % 10) == 3);
        end
        repeat (12) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    //----------------------------------------
    // Checks
    //----------------------------------------
    a_no_stray_done: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> pending)
    else begin
        $display("done_o pulsed with no request outstanding");
        stop_on_error();
    end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
    else begin
        $display("done_o stayed high for more than one cycle");
        stop_on_error();
    end

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept_pulse |-> (!done_o) [*8] ##1 done_o)
    else begin
        $display("done_o did not rise 7 cycles after an accepted start");
        stop_on_error();
    end

    a_best_mode: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> best_mode_o == exp_mode)
    else begin
        $display("error best_mode_o got %h expected %h",
                 $sampled(best_mode_o), $sampled(exp_mode));
        stop_on_error();
    end

    a_best_score: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> best_score_o == exp_score)
    else begin
        $display("error best_score_o got %h expected %h",
                 $sampled(best_score_o), $sampled(exp_score));
        stop_on_error();
    end

    a_best_pred: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> best_pred_o == exp_pred)
    else begin
        $display("error best_pred_o got %h expected %h",
                 $sampled(best_pred_o), $sampled(exp_pred));
        stop_on_error();
    end

endmodule

`default_nettype wire

/* build.f */
logic/intra4_pkg.sv
logic/intra4_predictor.sv
logic/intra4_sse.sv
logic/intra4_mode_select.sv
logic/intra4_top.sv
testbench/tb_intra4_top.sv
